/* design/test_signal_settings.svh */
// raster geometry for the test-signal video path
// sync placement within the line
// i2s framing and square tone period

`ifndef TEST_SIGNAL_SETTINGS_SVH
`define TEST_SIGNAL_SETTINGS_SVH

////////////////////
// horizontal timing, in mclk cycles
`define H_TOTAL 400
`define H_BPORCH 10
`define H_ACTIVE 320

////////////////////
// vertical timing, in lines
`define V_TOTAL 512
`define V_BPORCH 10
`define V_ACTIVE 240

// line clock that carries the hsync pulse
`define HS_POS 3

////////////////////
// i2s, sclk = mclk / SCLK_DIV
`define SCLK_DIV 4
`define SLOT_BITS 32
`define LEAD_ZERO_BITS 4

// slots per half period, ~440 hz at 48 khz stereo
`define TONE_SLOTS 109

`endif

/* design/test_signal_pkg.sv */
// shared types for the test-signal core
// coordinate and colour vectors, pattern enum
// beam struct passed from raster timing to the painter

package test_signal_pkg;

  ////////////////////
  // plain vectors

  // raster coordinate, covers 512 lines
  typedef logic [9:0] coord_t;

  // pixel colour, red in [23:16], green [15:8], blue [7:0]
  typedef logic [23:0] rgb_t;

  ////////////////////
  // test pattern select

  typedef enum logic [1:0] {
    pattern_plain      = 2'd0,
    pattern_vertical   = 2'd1,
    pattern_horizontal = 2'd2,
    pattern_checker    = 2'd3
  } pattern_e;

  ////////////////////
  // beam state, one per mclk

  // x, y are visible coordinates, porches already removed
  // only meaningful while de is high
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   de;
    logic   vs;
    logic   hs;
    // first cycle of a frame, same point as vs
    logic   frame_start;
  } beam_t;

endpackage

/* design/raster_timing.sv */
// horizontal and vertical raster counters
// sync, data enable and visible beam position, one register stage

`timescale 1ns/1ns

`include "test_signal_settings.svh"

module raster_timing (
  input  logic                  audgen_mclk,
  input  logic                  reset_n,
  output test_signal_pkg::beam_t beam
);

  import test_signal_pkg::*;

  ////////////////////
  // counter limits

  localparam coord_t H_LAST  = coord_t'(`H_TOTAL - 1);
  localparam coord_t V_LAST  = coord_t'(`V_TOTAL - 1);
  localparam coord_t H_START = coord_t'(`H_BPORCH);
  localparam coord_t H_END   = coord_t'(`H_BPORCH + `H_ACTIVE);
  localparam coord_t V_START = coord_t'(`V_BPORCH);
  localparam coord_t V_END   = coord_t'(`V_BPORCH + `V_ACTIVE);
  localparam coord_t HS_COL  = coord_t'(`HS_POS);

  // column and line counters
  coord_t h_count;
  coord_t v_count;

  // decoded from current counter state
  logic   h_active;
  logic   v_active;
  logic   at_origin;

  ////////////////////
  // counters

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      h_count <= '0;
      v_count <= '0;
    end else begin
      h_count <= h_count + coord_t'(1);
      // end of line
      if (h_count == H_LAST) begin
        h_count <= '0;
        v_count <= v_count + coord_t'(1);
        // wrap at end of frame
        if (v_count == V_LAST) begin
          v_count <= '0;
        end
      end
    end
  end

  // active window, porch first then visible area
  assign h_active  = (h_count >= H_START) && (h_count < H_END);
  assign v_active  = (v_count >= V_START) && (v_count < V_END);
  assign at_origin = (h_count == '0) && (v_count == '0);

  ////////////////////
  // beam register

  // outputs trail the counters by one clock
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      beam <= '0;
    end else begin
      beam.vs          <= at_origin;
      // frame start shares the vsync point
      beam.frame_start <= at_origin;
      beam.hs          <= (h_count == HS_COL);
      beam.de          <= h_active && v_active;
      // visible coords, wrap outside the window but de is low there
      beam.x           <= h_count - H_START;
      beam.y           <= v_count - V_START;
    end
  end

endmodule

/* design/pattern_painter.sv */
// per-frame latch of pattern select and docked
// border and test pattern colour decode
// output register for rgb with matching de, vs, hs

`timescale 1ns/1ns

`include "test_signal_settings.svh"

module pattern_painter (
  input  logic                     audgen_mclk,
  input  logic                     reset_n,
  input  test_signal_pkg::beam_t    beam,
  input  test_signal_pkg::pattern_e pattern_sel,
  input  logic                     docked,
  output test_signal_pkg::rgb_t     rgb,
  output logic                     de,
  output logic                     vs,
  output logic                     hs
);

  import test_signal_pkg::*;

  ////////////////////
  // colours and border positions

  localparam rgb_t COL_RED    = 24'hFF0000;
  localparam rgb_t COL_BLUE   = 24'h0000FF;
  localparam rgb_t COL_GREEN  = 24'h00FF00;
  localparam rgb_t COL_YELLOW = 24'hFFFF80;
  localparam rgb_t COL_WHITE  = 24'hFFFFFF;
  localparam rgb_t COL_BLACK  = 24'h000000;
  localparam rgb_t COL_PURPLE = 24'hA00080;

  localparam coord_t X_LAST = coord_t'(`H_ACTIVE - 1);
  localparam coord_t Y_LAST = coord_t'(`V_ACTIVE - 1);

  // settings held for the whole frame
  pattern_e pattern_q;
  logic     docked_q;

  // decode results
  logic     pix_on;
  rgb_t     pix_rgb;

  // inputs are static levels, taken once per frame
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      pattern_q <= pattern_checker;
      docked_q  <= 1'b0;
    end else if (beam.frame_start) begin
      pattern_q <= pattern_sel;
      docked_q  <= docked;
    end
  end

  ////////////////////
  // colour decode

  always_comb begin
    // stripe and checker parity
    case (pattern_q)
      pattern_horizontal: pix_on = beam.x[0];
      pattern_vertical:   pix_on = beam.y[0];
      pattern_checker:    pix_on = beam.x[0] ^ beam.y[0];
      default:            pix_on = 1'b0;
    endcase

    // border wins over pattern, top and bottom win over sides
    if (!beam.de) begin
      pix_rgb = COL_BLACK;
    end else if (beam.y == '0) begin
      pix_rgb = COL_RED;
    end else if (beam.y == Y_LAST) begin
      pix_rgb = COL_BLUE;
    end else if (beam.x == '0) begin
      pix_rgb = COL_GREEN;
    end else if (beam.x == X_LAST) begin
      pix_rgb = COL_YELLOW;
    end else if (pix_on) begin
      // docked flips the on colour to black
      pix_rgb = docked_q ? COL_BLACK : COL_WHITE;
    end else begin
      pix_rgb = COL_PURPLE;
    end
  end

  // output stage, all four together
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      rgb <= '0;
      de  <= 1'b0;
      vs  <= 1'b0;
      hs  <= 1'b0;
    end else begin
      rgb <= pix_rgb;
      de  <= beam.de;
      vs  <= beam.vs;
      hs  <= beam.hs;
    end
  end

endmodule

/* design/i2s_tone_gen.sv */
// bit clock phase counter, sclk = mclk / 4
// slot bit counter and word clock
// square tone oscillator, serial i2s data

`timescale 1ns/1ns

`include "test_signal_settings.svh"

module i2s_tone_gen (
  input  logic audgen_mclk,
  input  logic reset_n,
  output logic sclk,
  output logic lrck,
  output logic dac
);

  ////////////////////
  // widths

  localparam int PH_W  = $clog2(`SCLK_DIV);
  localparam int BIT_W = $clog2(`SLOT_BITS);
  localparam int OSC_W = $clog2(`TONE_SLOTS + 1);

  localparam logic [PH_W-1:0]  PH_LAST   = PH_W'(`SCLK_DIV - 1);
  localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(`SLOT_BITS - 1);
  localparam logic [BIT_W-1:0] LEAD_BITS = BIT_W'(`LEAD_ZERO_BITS);
  localparam logic [OSC_W-1:0] OSC_LAST  = OSC_W'(`TONE_SLOTS);

  // bit clock phase, 0..3
  logic [PH_W-1:0]  phase;
  // last mclk of the high half, sclk falls next edge
  logic             sclk_fall;
  // bit position within the channel slot
  logic [BIT_W-1:0] bit_cnt;
  // completed slots in this half period, 1..TONE_SLOTS
  logic [OSC_W-1:0] osc_cnt;
  logic             tone_high;

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      phase <= '0;
    end else begin
      phase <= phase + PH_W'(1);
    end
  end

  // top bit gives 2 high, 2 low
  assign sclk      = phase[PH_W-1];
  assign sclk_fall = (phase == PH_LAST);

  ////////////////////
  // slot framing and tone

  // dac, lrck move on the same edge that drops sclk
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      bit_cnt   <= '0;
      lrck      <= 1'b0;
      dac       <= 1'b0;
      osc_cnt   <= OSC_W'(1);
      tone_high <= 1'b0;
    end else if (sclk_fall) begin
      // zero lead-in, then tone level for the rest of the slot
      dac     <= (bit_cnt < LEAD_BITS) ? 1'b0 : tone_high;
      bit_cnt <= bit_cnt + BIT_W'(1);
      if (bit_cnt == BIT_LAST) begin
        // switch channels
        lrck <= ~lrck;
        if (osc_cnt < OSC_LAST) begin
          osc_cnt <= osc_cnt + OSC_W'(1);
        end else begin
          // half period done
          osc_cnt   <= OSC_W'(1);
          tone_high <= ~tone_high;
        end
      end
    end
  end

endmodule

/* design/test_signal_top.sv */
// test-signal core top level
// raster timing into the pattern painter for video
// independent i2s tone generator for audio

`timescale 1ns/1ns

module test_signal_top (
  input  logic                     audgen_mclk,
  input  logic                     reset_n,
  input  test_signal_pkg::pattern_e pattern_sel,
  input  logic                     docked,
  output test_signal_pkg::rgb_t     video_rgb,
  output logic                     video_de,
  output logic                     video_vs,
  output logic                     video_hs,
  output logic                     audio_mclk,
  output logic                     audio_sclk,
  output logic                     audio_lrck,
  output logic                     audio_dac
);

  import test_signal_pkg::*;

  ////////////////////
  // video path

  // beam from counters, valid every clock
  beam_t beam;

  raster_timing u_raster_timing (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .beam        (beam)
  );

  pattern_painter u_pattern_painter (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .beam        (beam),
    .pattern_sel (pattern_sel),
    .docked      (docked),
    .rgb         (video_rgb),
    .de          (video_de),
    .vs          (video_vs),
    .hs          (video_hs)
  );

  ////////////////////
  // audio path

  // codec master clock is the core clock itself
  assign audio_mclk = audgen_mclk;

  i2s_tone_gen u_i2s_tone_gen (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .sclk        (audio_sclk),
    .lrck        (audio_lrck),
    .dac         (audio_dac)
  );

endmodule

/* testbench/tb_test_signal_top.sv */
// testbench for the test-signal core
// lfsr choice of pattern and docked per frame, own raster counters
// assertion checks on video timing, colours and i2s framing

`timescale 1ns/1ns

`include "test_signal_settings.svh"

module tb_test_signal_top;

  import test_signal_pkg::*;

  // enough frames for every pattern plus one free lfsr pick
  localparam int N_FRAMES   = 5;
  localparam int VS_TIMEOUT = `H_TOTAL * `V_TOTAL + 16;

  logic     audgen_mclk;
  logic     reset_n;
  pattern_e pattern_sel;
  logic     docked;
  rgb_t     video_rgb;
  logic     video_de;
  logic     video_vs;
  logic     video_hs;
  logic     audio_mclk;
  logic     audio_sclk;
  logic     audio_lrck;
  logic     audio_dac;

  // per test: reset, sync, border, pattern, i2s, tone
  int       checks [6];
  int       errors [6];
  bit       seen_pat [4];
  bit       seen_dock [2];
  // settings of frames that were checked from vs to vs
  bit       shown_pat [4];
  bit       shown_dock [2];
  bit       timed_out;
  logic [31:0] lfsr;

  // video reference state
  bit       synced;
  int       col;
  int       line;
  int       de_lines;
  int       frames_seen;
  int       pix_x;
  int       pix_y;
  bit       border;
  pattern_e cur_pat;
  pattern_e prev_pat;
  logic     cur_dock;
  logic     prev_dock;
  logic     prev_de;

  // i2s reference state
  logic     prev_sclk;
  logic     prev_lrck;
  logic     prev_dac;
  logic     fell;
  logic     slot_level;
  logic     last_level;
  int       sclk_run;
  int       sclk_edges;
  int       fall_cnt;
  int       falls_since_lr;
  int       bit_idx;
  int       flips;
  int       post_reset;

  test_signal_top u_dut (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .pattern_sel (pattern_sel),
    .docked      (docked),
    .video_rgb   (video_rgb),
    .video_de    (video_de),
    .video_vs    (video_vs),
    .video_hs    (video_hs),
    .audio_mclk  (audio_mclk),
    .audio_sclk  (audio_sclk),
    .audio_lrck  (audio_lrck),
    .audio_dac   (audio_dac)
  );

  always #5 audgen_mclk = ~audgen_mclk;

  ////////////////////
  // helpers

  function automatic string test_name(input int t);
    case (t)
      0: return "reset";
      1: return "sync";
      2: return "border";
      3: return "pattern";
      4: return "i2s";
      default: return "tone";
    endcase
  endfunction

  task automatic check_value(input int t, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks[t]++;
    assert (got === exp) else begin
      $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      errors[t]++;
    end
  endtask

  task automatic report_test(input int t);
    $display("test %s: %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
  endtask

  // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // colour from visible position, border before pattern
  function automatic rgb_t expected_rgb(input int x, input int y, input pattern_e pat,
                                        input logic dock);
    logic lit;
    if (y == 0) return 24'hFF0000;
    if (y == `V_ACTIVE - 1) return 24'h0000FF;
    if (x == 0) return 24'h00FF00;
    if (x == `H_ACTIVE - 1) return 24'hFFFF80;
    lit = 1'b0;
    if (pat == pattern_horizontal) lit = (x % 2 == 1);
    if (pat == pattern_vertical) lit = (y % 2 == 1);
    // checker lit where x and y parities differ
    if (pat == pattern_checker) lit = ((x + y) % 2 == 1);
    if (lit) return dock ? 24'h000000 : 24'hFFFFFF;
    return 24'hA00080;
  endfunction

  // three lfsr bits, overridden when the remaining frames must cover gaps
  task automatic choose_inputs(input int frames_left);
    logic [1:0] pat_bits;
    logic       dock_bit;
    int         missing;
    int         first_free;
    int         p;
    lfsr = lfsr_step(lfsr);
    pat_bits[0] = lfsr[0];
    lfsr = lfsr_step(lfsr);
    pat_bits[1] = lfsr[0];
    lfsr = lfsr_step(lfsr);
    dock_bit = lfsr[0];
    missing = 0;
    first_free = 0;
    for (p = 3; p >= 0; p--) begin
      if (!seen_pat[p]) begin
        missing++;
        first_free = p;
      end
    end
    if (missing >= frames_left) pat_bits = first_free[1:0];
    if (frames_left == 1 && !seen_dock[0]) dock_bit = 1'b0;
    if (frames_left == 1 && !seen_dock[1]) dock_bit = 1'b1;
    seen_pat[pat_bits] = 1'b1;
    seen_dock[dock_bit] = 1'b1;
    pattern_sel = pattern_e'(pat_bits);
    docked = dock_bit;
    $display("next frame: pattern %s docked %0b", pattern_sel.name(), docked);
  endtask

  task automatic wait_for_vs(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(posedge audgen_mclk);
      #1;
      cycles++;
    end while (!video_vs && cycles < VS_TIMEOUT);
    if (!video_vs) begin
      $display("timeout: no video_vs %s within %0d clocks", what, VS_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  ////////////////////
  // reset state

  always @(negedge audgen_mclk) begin
    if (!reset_n || post_reset < 2) begin
      check_value(0, "video_de", video_de, 0);
      check_value(0, "video_vs", video_vs, 0);
      check_value(0, "video_hs", video_hs, 0);
      check_value(0, "video_rgb", video_rgb, 0);
      check_value(0, "audio_lrck", audio_lrck, 0);
      check_value(0, "audio_dac", audio_dac, 0);
      if (reset_n) begin
        post_reset++;
        if (post_reset == 2) report_test(0);
      end
    end
  end

  ////////////////////
  // video, own counters locked to the first vs

  always @(negedge audgen_mclk) begin
    if (!reset_n) begin
      synced = 1'b0;
      de_lines = 0;
      frames_seen = 0;
      prev_de = 1'b0;
    end else begin
      if (synced) begin
        col++;
        if (col == `H_TOTAL) begin
          col = 0;
          line = (line + 1) % `V_TOTAL;
        end
      end else if (video_vs) begin
        synced = 1'b1;
        col = 0;
        line = 0;
      end
      if (synced) begin
        // frame point, dut latched the inputs seen one clock earlier
        if (col == 0 && line == 0) begin
          if (frames_seen > 0) begin
            check_value(1, "video_de lines per frame", de_lines, `V_ACTIVE);
            // the frame that just ended ran with these settings
            shown_pat[cur_pat] = 1'b1;
            shown_dock[cur_dock] = 1'b1;
          end
          de_lines = 0;
          frames_seen++;
          cur_pat = prev_pat;
          cur_dock = prev_dock;
        end
        if (video_de && !prev_de) de_lines++;
        check_value(1, "video_vs", video_vs, col == 0 && line == 0);
        check_value(1, "video_hs", video_hs, col == `HS_POS);
        pix_x = col - `H_BPORCH;
        pix_y = line - `V_BPORCH;
        if (pix_x >= 0 && pix_x < `H_ACTIVE && pix_y >= 0 && pix_y < `V_ACTIVE) begin
          check_value(1, "video_de", video_de, 1);
          border = (pix_y == 0 || pix_y == `V_ACTIVE - 1 || pix_x == 0 || pix_x == `H_ACTIVE - 1);
          check_value(border ? 2 : 3, "video_rgb", video_rgb,
                      expected_rgb(pix_x, pix_y, cur_pat, cur_dock));
        end else begin
          check_value(1, "video_de", video_de, 0);
          check_value(3, "video_rgb", video_rgb, 0);
        end
      end else begin
        check_value(1, "video_hs", video_hs, 0);
        check_value(1, "video_de", video_de, 0);
      end
      prev_de = video_de;
      prev_pat = pattern_sel;
      prev_dock = docked;
    end
  end

  ////////////////////
  // i2s framing and tone level

  always @(negedge audgen_mclk) begin
    if (!reset_n) begin
      prev_sclk = 1'b0;
      prev_lrck = 1'b0;
      prev_dac = 1'b0;
      last_level = 1'b0;
      sclk_run = 0;
      sclk_edges = 0;
      fall_cnt = 0;
      falls_since_lr = 0;
      flips = 0;
    end else begin
      fell = prev_sclk && !audio_sclk;
      // two high, two low
      if (audio_sclk != prev_sclk) begin
        if (sclk_edges > 0) check_value(4, "audio_sclk half period", sclk_run, 2);
        sclk_edges++;
        sclk_run = 1;
      end else begin
        sclk_run++;
      end
      if (audio_lrck != prev_lrck || audio_dac != prev_dac) begin
        check_value(4, "sclk fall at data change", fell, 1);
      end
      if (fell) begin
        bit_idx = fall_cnt % `SLOT_BITS;
        if (bit_idx < `LEAD_ZERO_BITS) begin
          check_value(4, "audio_dac lead-in", audio_dac, 0);
        end else if (bit_idx == `LEAD_ZERO_BITS) begin
          slot_level = audio_dac;
          check_value(5, "tone level", slot_level,
                      ((fall_cnt / `SLOT_BITS) / `TONE_SLOTS) % 2);
          if (slot_level !== last_level) flips++;
          last_level = slot_level;
        end else begin
          check_value(4, "audio_dac slot bit", audio_dac, slot_level);
        end
        falls_since_lr++;
        fall_cnt++;
      end
      // lrck moves with the last bit of each slot
      if (audio_lrck != prev_lrck) begin
        check_value(4, "sclk falls per lrck", falls_since_lr, `SLOT_BITS);
        falls_since_lr = 0;
      end
      prev_sclk = audio_sclk;
      prev_lrck = audio_lrck;
      prev_dac = audio_dac;
    end
  end

  ////////////////////
  // codec master clock follows the core clock

  always @(audgen_mclk) begin
    #1;
    check_value(4, "audio_mclk", audio_mclk, audgen_mclk);
  end

  ////////////////////
  // stimulus and report

  initial begin : main_seq
    int f;
    int total_checks;
    int total_errors;
    audgen_mclk = 1'b0;
    reset_n = 1'b0;
    lfsr = 32'h0433_8559;
    choose_inputs(N_FRAMES);
    repeat (8) @(posedge audgen_mclk);
    #1;
    reset_n = 1'b1;
    wait_for_vs("after reset");
    // new values go in right after a vs, taken at the next one
    for (f = 1; f < N_FRAMES; f++) begin
      if (!timed_out) choose_inputs(N_FRAMES - f);
      if (!timed_out) wait_for_vs("for next frame");
    end
    if (!timed_out) wait_for_vs("at end of last frame");
    // let the checker see the closing frame point
    repeat (2) @(posedge audgen_mclk);
    for (f = 0; f < 4; f++) begin
      checks[3]++;
      assert (shown_pat[f]) else begin
        $display("pattern %0d was never shown", f);
        errors[3]++;
      end
    end
    for (f = 0; f < 2; f++) begin
      checks[3]++;
      assert (shown_dock[f]) else begin
        $display("docked %0d was never shown", f);
        errors[3]++;
      end
    end
    checks[5]++;
    assert (flips >= 3) else begin
      $display("tone level flipped only %0d times, at least 3 needed", flips);
      errors[5]++;
    end
    total_checks = 0;
    total_errors = 0;
    for (f = 0; f < 6; f++) begin
      if (f > 0) report_test(f);
      total_checks += checks[f];
      total_errors += errors[f];
    end
    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+design
design/test_signal_pkg.sv
design/raster_timing.sv
design/pattern_painter.sv
design/i2s_tone_gen.sv
design/test_signal_top.sv
testbench/tb_test_signal_top.sv

/* Bender.yml */
package:
  name: test_signal

export_include_dirs:
  - design

sources:
  - files:
      - design/test_signal_pkg.sv
      - design/raster_timing.sv
      - design/pattern_painter.sv
      - design/i2s_tone_gen.sv
      - design/test_signal_top.sv
  - target: test
    files:
      - testbench/tb_test_signal_top.sv
